// File: Bender.yml
package:
  name: conv3x3

sources:
  - files:
      - src/conv_pkg.sv
      - src/conv_ctrl.sv
      - src/window_fetch.sv
      - src/weight_decode.sv
      - src/mac_requant.sv
      - src/conv3x3_top.sv
  - target: simulation
    files:
      - sim/conv_mem_model.sv
      - sim/conv3x3_tb.sv

// File: sim.f
src/conv_pkg.sv
src/conv_ctrl.sv
src/window_fetch.sv
src/weight_decode.sv
src/mac_requant.sv
src/conv3x3_top.sv
sim/conv_mem_model.sv
sim/conv3x3_tb.sv

// File: sim/conv3x3_tb.sv
`timescale 1ns/1ps

module conv3x3_tb;
  import conv_pkg::*;

  logic clk;
  logic rstn;
  logic start;
  logic [PAL_W-1:0] w8;
  logic busy;
  logic finish;
  logic param_en;
  logic [ADDR_W-1:0] param_addr;
  logic [31:0] param_rdata;
  logic bias_en;
  logic [ADDR_W-1:0] bias_addr;
  logic [31:0] bias_rdata;
  logic weight_en;
  logic [ADDR_W-1:0] weight_addr;
  logic [CODE_W-1:0] weight_rdata;
  logic input_en;
  logic [ADDR_W-1:0] input_addr;
  logic [DATA_W-1:0] input_rdata;
  logic out_en;
  logic out_we;
  logic [ADDR_W-1:0] out_addr;
  logic [ACC_W-1:0] out_wdata;
  logic [ACC_W-1:0] out_rdata;
  logic [31:0] out_writes;

  integer seed;
  logic [PAL_W-1:0] pal;
  int exp_out [1024];
  string cur_test;
  int test_errs;
  int tests_ok;
  int tests_bad;
  int finish_cnt;
  int jobs_run;
  int w0;

  conv3x3_top conv3x3_top_i (
    .clk          (clk),
    .rstn         (rstn),
    .start        (start),
    .w8           (w8),
    .busy         (busy),
    .finish       (finish),
    .param_en     (param_en),
    .param_addr   (param_addr),
    .param_rdata  (param_rdata),
    .bias_en      (bias_en),
    .bias_addr    (bias_addr),
    .bias_rdata   (bias_rdata),
    .weight_en    (weight_en),
    .weight_addr  (weight_addr),
    .weight_rdata (weight_rdata),
    .input_en     (input_en),
    .input_addr   (input_addr),
    .input_rdata  (input_rdata),
    .out_en       (out_en),
    .out_we       (out_we),
    .out_addr     (out_addr),
    .out_wdata    (out_wdata),
    .out_rdata    (out_rdata)
  );

  conv_mem_model #(.WIDTH(32)) param_mem_i (
    .clk(clk), .rstn(rstn), .en(param_en), .we(1'b0), .addr(param_addr),
    .wdata('0), .rdata(param_rdata), .writes()
  );

  conv_mem_model #(.WIDTH(32)) bias_mem_i (
    .clk(clk), .rstn(rstn), .en(bias_en), .we(1'b0), .addr(bias_addr),
    .wdata('0), .rdata(bias_rdata), .writes()
  );

  conv_mem_model #(.WIDTH(CODE_W)) weight_mem_i (
    .clk(clk), .rstn(rstn), .en(weight_en), .we(1'b0), .addr(weight_addr),
    .wdata('0), .rdata(weight_rdata), .writes()
  );

  conv_mem_model #(.WIDTH(DATA_W)) input_mem_i (
    .clk(clk), .rstn(rstn), .en(input_en), .we(1'b0), .addr(input_addr),
    .wdata('0), .rdata(input_rdata), .writes()
  );

  conv_mem_model #(.WIDTH(ACC_W)) out_mem_i (
    .clk(clk), .rstn(rstn), .en(out_en), .we(out_we), .addr(out_addr),
    .wdata(out_wdata), .rdata(out_rdata), .writes(out_writes)
  );

  always #4 clk = ~clk;

  // count cycles with finish high
  always @(negedge clk) begin
    if (finish) finish_cnt++;
  end

  task automatic check(input string what, input int exp, input int got);
    assert (exp == got) else begin
      $display("[ERROR] %s %s: expected %0d, got %0d", cur_test, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      tests_ok++;
      $display("test %s: ok", cur_test);
    end else begin
      tests_bad++;
      $display("test %s: FAILED with %0d errors", cur_test, test_errs);
    end
  endtask

  function automatic int wrap16(input int v);
    logic signed [15:0] t;
    t = v[15:0];
    return int'(t);
  endfunction

  // relu, saturate at 4096 and above, else drop 5 fraction bits
  function automatic int relu_requant(input int v);
    if (v < 0) return 0;
    if (v >= 4096) return REQ_MAX;
    return v >>> REQ_SHIFT;
  endfunction

  task automatic fill_random(input int side, input int nch, input int nker);
    param_mem_i.mem[0] = side;
    param_mem_i.mem[1] = nch;
    param_mem_i.mem[2] = nker;
    for (int k = 0; k < nker; k++) bias_mem_i.mem[k] = $random(seed) % 256;
    for (int i = 0; i < nker * nch; i++) weight_mem_i.mem[i] = $random(seed);
    for (int i = 0; i < nch * side * side; i++) begin
      input_mem_i.mem[i] = 8'($random(seed) % 32);
    end
    for (int b = 0; b < 4; b++) pal[8*b +: 8] = 8'($random(seed) % 16);
    // stale contents, should never leak into a first channel
    for (int i = 0; i < 1024; i++) out_mem_i.mem[i] = 16'(i * 40503 + 17);
  endtask

  task automatic compute_model(input int side, input int nch, input int nker);
    int acc;
    int sum;
    int nr;
    int nc;
    int px;
    int w;
    logic [CODE_W-1:0] code;
    for (int k = 0; k < nker; k++) begin
      for (int r = 0; r < side; r++) begin
        for (int c = 0; c < side; c++) begin
          acc = wrap16(bias_mem_i.mem[k][15:0]);
          for (int ch = 0; ch < nch; ch++) begin
            code = weight_mem_i.mem[k * nch + ch];
            sum = 0;
            for (int t = 0; t < 9; t++) begin
              nr = r + t / 3 - 1;
              nc = c + t % 3 - 1;
              px = 0;
              if (nr >= 0 && nr < side && nc >= 0 && nc < side) begin
                px = $signed(input_mem_i.mem[ch * side * side + nr * side + nc]);
              end
              w = $signed(pal[8 * code[2*t +: 2] +: 8]);
              sum += px * w;
            end
            acc = wrap16(acc + wrap16(sum));
          end
          exp_out[k * side * side + r * side + c] = relu_requant(acc);
        end
      end
    end
  endtask

  task automatic run_job(input logic pulse_again, input int limit);
    int n;
    @(negedge clk);
    w8    = pal;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    jobs_run++;
    check("busy after start", 1, busy);
    if (pulse_again) begin
      repeat (6) @(negedge clk);
      w8    = ~pal;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    n = 0;
    while (!finish && n < limit) begin
      check("busy during job", 1, busy);
      @(negedge clk);
      n++;
    end
    if (!finish) begin
      $display("timeout: finish did not rise within %0d cycles", limit);
      $display("Test failures found");
      $finish;
    end else begin
      @(negedge clk);
      check("finish width", 0, finish);
      check("busy after finish", 0, busy);
    end
  endtask

  task automatic check_outputs(input int total);
    for (int i = 0; i < total; i++) begin
      check($sformatf("out[%0d]", i), exp_out[i], int'($signed(out_mem_i.mem[i])));
    end
  endtask

  initial begin
    clk        = 1'b0;
    rstn       = 1'b0;
    start      = 1'b0;
    w8         = '0;
    pal        = '0;
    seed       = 81487;
    tests_ok   = 0;
    tests_bad  = 0;
    finish_cnt = 0;
    jobs_run   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    begin_test("reset_idle");
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check("busy", 0, busy);
      check("finish", 0, finish);
      check("param_en", 0, param_en);
      check("bias_en", 0, bias_en);
      check("weight_en", 0, weight_en);
      check("input_en", 0, input_en);
      check("out_en", 0, out_en);
      check("out_we", 0, out_we);
    end
    check("writes", 0, out_writes);
    end_test();

    begin_test("single_kernel");
    fill_random(4, 1, 1);
    compute_model(4, 1, 1);
    run_job(1'b0, 20000);
    check_outputs(16);
    end_test();

    begin_test("multi_kernel_channel");
    fill_random(5, 3, 2);
    compute_model(5, 3, 2);
    run_job(1'b0, 20000);
    check_outputs(50);
    end_test();

    // weight 16 everywhere, top half +100, bottom half -100
    begin_test("saturation");
    fill_random(4, 1, 1);
    pal = {8'd0, 8'd0, 8'd0, 8'd16};
    weight_mem_i.mem[0] = '0;
    bias_mem_i.mem[0] = '0;
    for (int i = 0; i < 16; i++) input_mem_i.mem[i] = (i < 8) ? 8'd100 : 8'(-100);
    compute_model(4, 1, 1);
    run_job(1'b0, 20000);
    check_outputs(16);
    check("top corner", 127, int'($signed(out_mem_i.mem[0])));
    check("bottom corner", 0, int'($signed(out_mem_i.mem[15])));
    end_test();

    begin_test("start_while_busy");
    fill_random(3, 2, 1);
    compute_model(3, 2, 1);
    w0 = out_writes;
    run_job(1'b1, 20000);
    check("write count", 1 * 2 * 3 * 3, out_writes - w0);
    check_outputs(9);
    for (int b = 0; b < 4; b++) pal[8*b +: 8] = 8'($random(seed) % 16);
    compute_model(3, 2, 1);
    w0 = out_writes;
    run_job(1'b0, 20000);
    check("second write count", 1 * 2 * 3 * 3, out_writes - w0);
    check_outputs(9);
    end_test();

    begin_test("finish_pulse");
    fill_random(2, 1, 1);
    compute_model(2, 1, 1);
    run_job(1'b0, 20000);
    run_job(1'b0, 20000);
    check_outputs(4);
    check("finish cycles", jobs_run, finish_cnt);
    end_test();

    $display("results: %0d tests ok, %0d tests failed", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: sim/conv_mem_model.sv
`timescale 1ns/1ps

module conv_mem_model #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 1024
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             en,
  input  logic             we,
  input  logic [15:0]      addr,
  input  logic [WIDTH-1:0] wdata,
  output logic [WIDTH-1:0] rdata,
  output logic [31:0]      writes
);

  // contents are preloaded and inspected by the testbench
  logic [WIDTH-1:0] mem [DEPTH];

  // one-cycle read latency, a write keeps the last read data
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata  <= '0;
      writes <= '0;
    end else if (en) begin
      if (we) begin
        mem[addr] <= wdata;
        writes    <= writes + 1;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

// File: src/conv3x3_top.sv
`timescale 1ns/1ps

module conv3x3_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start,
  input  logic [conv_pkg::PAL_W-1:0]  w8,
  output logic                        busy,
  output logic                        finish,
  output logic                        param_en,
  output logic [conv_pkg::ADDR_W-1:0] param_addr,
  input  logic [31:0]                 param_rdata,
  output logic                        bias_en,
  output logic [conv_pkg::ADDR_W-1:0] bias_addr,
  input  logic [31:0]                 bias_rdata,
  output logic                        weight_en,
  output logic [conv_pkg::ADDR_W-1:0] weight_addr,
  input  logic [conv_pkg::CODE_W-1:0] weight_rdata,
  output logic                        input_en,
  output logic [conv_pkg::ADDR_W-1:0] input_addr,
  input  logic [conv_pkg::DATA_W-1:0] input_rdata,
  output logic                        out_en,
  output logic                        out_we,
  output logic [conv_pkg::ADDR_W-1:0] out_addr,
  output logic [conv_pkg::ACC_W-1:0]  out_wdata,
  input  logic [conv_pkg::ACC_W-1:0]  out_rdata
);
  import conv_pkg::*;

  logic accept;
  logic code_load;
  logic fetch_go;
  logic fetch_done;
  logic calc;
  logic first_ch;
  logic last_ch;
  logic [ROW_W-1:0] row;
  logic [ROW_W-1:0] col;
  logic [ROW_W-1:0] side;
  logic [ADDR_W-1:0] chan_base;
  acc_t bias;
  window_t window;
  weights_t weights;

  conv_ctrl ctrl_i (
    .clk         (clk),
    .rstn        (rstn),
    .start       (start),
    .busy        (busy),
    .finish      (finish),
    .accept      (accept),
    .param_en    (param_en),
    .bias_en     (bias_en),
    .weight_en   (weight_en),
    .out_en      (out_en),
    .out_we      (out_we),
    .param_addr  (param_addr),
    .bias_addr   (bias_addr),
    .weight_addr (weight_addr),
    .out_addr    (out_addr),
    .param_rdata (param_rdata),
    .bias_rdata  (bias_rdata),
    .code_load   (code_load),
    .fetch_go    (fetch_go),
    .fetch_done  (fetch_done),
    .row         (row),
    .col         (col),
    .chan_base   (chan_base),
    .side        (side),
    .calc        (calc),
    .first_ch    (first_ch),
    .last_ch     (last_ch),
    .bias        (bias)
  );

  window_fetch fetch_i (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_go    (fetch_go),
    .row         (row),
    .col         (col),
    .side        (side),
    .chan_base   (chan_base),
    .input_en    (input_en),
    .input_addr  (input_addr),
    .input_rdata (input_rdata),
    .fetch_done  (fetch_done),
    .window      (window)
  );

  weight_decode decode_i (
    .clk          (clk),
    .rstn         (rstn),
    .accept       (accept),
    .w8           (w8),
    .code_load    (code_load),
    .weight_rdata (weight_rdata),
    .weights      (weights)
  );

  mac_requant mac_i (
    .clk       (clk),
    .rstn      (rstn),
    .calc      (calc),
    .window    (window),
    .weights   (weights),
    .first_ch  (first_ch),
    .last_ch   (last_ch),
    .bias      (bias),
    .out_rdata (out_rdata),
    .out_wdata (out_wdata)
  );

endmodule

// File: src/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start,
  output logic                        busy,
  output logic                        finish,
  output logic                        accept,
  output logic                        param_en,
  output logic                        bias_en,
  output logic                        weight_en,
  output logic                        out_en,
  output logic                        out_we,
  output logic [conv_pkg::ADDR_W-1:0] param_addr,
  output logic [conv_pkg::ADDR_W-1:0] bias_addr,
  output logic [conv_pkg::ADDR_W-1:0] weight_addr,
  output logic [conv_pkg::ADDR_W-1:0] out_addr,
  input  logic [31:0]                 param_rdata,
  input  logic [31:0]                 bias_rdata,
  output logic                        code_load,
  output logic                        fetch_go,
  input  logic                        fetch_done,
  output logic [conv_pkg::ROW_W-1:0]  row,
  output logic [conv_pkg::ROW_W-1:0]  col,
  output logic [conv_pkg::ADDR_W-1:0] chan_base,
  output logic [conv_pkg::ROW_W-1:0]  side,
  output logic                        calc,
  output logic                        first_ch,
  output logic                        last_ch,
  output conv_pkg::acc_t              bias
);
  import conv_pkg::*;

  phase_t phase;
  phase_t phase_nxt;
  logic [3:0] cnt;
  logic [CH_W-1:0] num_ch;
  logic [CH_W-1:0] num_ker;
  logic [CH_W-1:0] ch;
  logic [CH_W-1:0] ker;
  logic [ADDR_W-1:0] plane;
  logic last_col;
  logic last_row;
  logic last_ker;
  logic last_pix;

  assign accept   = start && !busy;
  assign last_col = col == side - 1'b1;
  assign last_row = row == side - 1'b1;
  assign last_pix = last_col && last_row;
  assign first_ch = ch == '0;
  assign last_ch  = ch == num_ch - 1'b1;
  assign last_ker = ker == num_ker - 1'b1;
  assign plane    = ADDR_W'(side) * ADDR_W'(side);

  always_comb begin
    phase_nxt = phase;
    case (phase)
      idle:        if (accept) phase_nxt = load_param;
      load_param:  if (cnt == 4'd3) phase_nxt = load_bias;
      load_bias:   if (cnt == 4'd1) phase_nxt = load_weight;
      load_weight: if (cnt == 4'd1) phase_nxt = fetch;
      fetch:       if (fetch_done) phase_nxt = conv_pkg::calc;
      conv_pkg::calc: phase_nxt = read_out;
      read_out:    if (cnt == 4'd1) phase_nxt = write_out;
      write_out: begin
        // innermost loop first: pixel, channel, kernel
        if (!last_pix) phase_nxt = fetch;
        else if (!last_ch) phase_nxt = load_weight;
        else if (!last_ker) phase_nxt = load_bias;
        else phase_nxt = idle;
      end
      default: phase_nxt = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase <= idle;
      cnt   <= '0;
    end else begin
      phase <= phase_nxt;
      cnt   <= (phase_nxt != phase) ? '0 : cnt + 1'b1;
    end
  end

  // busy stays up for the finish cycle so a start there is ignored
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy   <= 1'b0;
      finish <= 1'b0;
    end else begin
      finish <= (phase == write_out) && (phase_nxt == idle);
      if (accept) busy <= 1'b1;
      else if (finish) busy <= 1'b0;
    end
  end

  // job size arrives one cycle after each param read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      side    <= '0;
      num_ch  <= '0;
      num_ker <= '0;
    end else if (phase == load_param) begin
      case (cnt)
        4'd1: side <= param_rdata[ROW_W-1:0];
        4'd2: num_ch <= param_rdata[CH_W-1:0];
        4'd3: num_ker <= param_rdata[CH_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == load_bias && cnt == 4'd1) bias <= acc_t'(bias_rdata[ACC_W-1:0]);
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      col <= '0;
      row <= '0;
      ch  <= '0;
      ker <= '0;
    end else if (accept) begin
      col <= '0;
      row <= '0;
      ch  <= '0;
      ker <= '0;
    end else if (phase == write_out) begin
      col <= last_col ? '0 : col + 1'b1;
      if (last_col) row <= last_row ? '0 : row + 1'b1;
      if (last_pix) ch <= last_ch ? '0 : ch + 1'b1;
      if (last_pix && last_ch) ker <= last_ker ? '0 : ker + 1'b1;
    end
  end

  // three param reads, data latched one cycle behind
  assign param_en = (phase == load_param) && (cnt < 4'd3);

  always_comb begin
    case (cnt[1:0])
      2'd0:    param_addr = PARAM_ROW_ADDR;
      2'd1:    param_addr = PARAM_CH_ADDR;
      default: param_addr = PARAM_KER_ADDR;
    endcase
  end

  assign bias_en     = (phase == load_bias) && (cnt == 4'd0);
  assign bias_addr   = ADDR_W'(ker);
  assign weight_en   = (phase == load_weight) && (cnt == 4'd0);
  assign weight_addr = ADDR_W'(ker) * ADDR_W'(num_ch) + ADDR_W'(ch);
  assign code_load   = (phase == load_weight) && (cnt == 4'd1);

  assign fetch_go  = (phase == fetch) && (cnt == 4'd0);
  assign chan_base = ADDR_W'(ch) * plane;
  assign calc      = phase == conv_pkg::calc;

  // old output only needed once the first channel is in
  assign out_en   = ((phase == read_out) && !first_ch) || (phase == write_out);
  assign out_we   = phase == write_out;
  assign out_addr = ADDR_W'(ker) * plane + ADDR_W'(row) * ADDR_W'(side) + ADDR_W'(col);

endmodule

// File: src/conv_pkg.sv
package conv_pkg;

  // memory and datapath widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;
  localparam int ACC_W  = 16;
  localparam int CODE_W = 18;
  localparam int PAL_W  = 32;
  localparam int TAPS   = 9;

  // loop counter widths, side up to 31
  localparam int ROW_W = 5;
  localparam int CH_W  = 8;

  // parameter memory layout
  localparam logic [ADDR_W-1:0] PARAM_ROW_ADDR = 16'd0;
  localparam logic [ADDR_W-1:0] PARAM_CH_ADDR  = 16'd1;
  localparam logic [ADDR_W-1:0] PARAM_KER_ADDR = 16'd2;

  // requantizer
  localparam int REQ_SHIFT = 5;
  localparam int REQ_MAX   = 127;

  typedef enum logic [2:0] {
    idle,
    load_param,
    load_bias,
    load_weight,
    fetch,
    calc,
    read_out,
    write_out
  } phase_t;

  typedef logic signed [DATA_W-1:0] pixel_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // tap i sits at row offset i/3 - 1, column offset i%3 - 1
  typedef pixel_t [TAPS-1:0] window_t;
  typedef pixel_t [TAPS-1:0] weights_t;

endpackage

// File: src/mac_requant.sv
`timescale 1ns/1ps

module mac_requant (
  input  logic               clk,
  input  logic               rstn,
  input  logic               calc,
  input  conv_pkg::window_t  window,
  input  conv_pkg::weights_t weights,
  input  logic               first_ch,
  input  logic               last_ch,
  input  conv_pkg::acc_t     bias,
  input  conv_pkg::acc_t     out_rdata,
  output conv_pkg::acc_t     out_wdata
);
  import conv_pkg::*;

  acc_t prod [TAPS];
  acc_t tree_sum;
  acc_t conv_sum;
  acc_t combined;

  always_comb begin
    for (int i = 0; i < TAPS; i++) begin
      prod[i] = acc_t'($signed(window[i]) * $signed(weights[i]));
    end
  end

  // 16-bit wrapping adds throughout
  assign tree_sum = ((prod[0] + prod[1]) + (prod[2] + prod[3])) +
                    ((prod[4] + prod[5]) + (prod[6] + prod[7])) + prod[8];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) conv_sum <= '0;
    else if (calc) conv_sum <= tree_sum;
  end

  // bias seeds the first channel, later ones add onto memory
  assign combined = (first_ch ? bias : out_rdata) + conv_sum;

  always_comb begin
    if (!last_ch) out_wdata = combined;
    else if (combined[ACC_W-1]) out_wdata = '0;
    else if (|combined[ACC_W-1:REQ_SHIFT+DATA_W-1]) out_wdata = acc_t'(REQ_MAX);
    else out_wdata = combined >>> REQ_SHIFT;
  end

endmodule

// File: src/weight_decode.sv
`timescale 1ns/1ps

module weight_decode (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        accept,
  input  logic [conv_pkg::PAL_W-1:0]  w8,
  input  logic                        code_load,
  input  logic [conv_pkg::CODE_W-1:0] weight_rdata,
  output conv_pkg::weights_t          weights
);
  import conv_pkg::*;

  logic [PAL_W-1:0] palette;

  // field value n picks palette byte n
  function automatic pixel_t pick(input logic [PAL_W-1:0] pal, input logic [1:0] sel);
    pick = pixel_t'(pal[DATA_W*sel +: DATA_W]);
  endfunction

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) palette <= '0;
    else if (accept) palette <= w8;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      weights <= '0;
    end else if (code_load) begin
      for (int i = 0; i < TAPS; i++) begin
        weights[i] <= pick(palette, weight_rdata[2*i +: 2]);
      end
    end
  end

endmodule

// File: src/window_fetch.sv
`timescale 1ns/1ps

module window_fetch (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        fetch_go,
  input  logic [conv_pkg::ROW_W-1:0]  row,
  input  logic [conv_pkg::ROW_W-1:0]  col,
  input  logic [conv_pkg::ROW_W-1:0]  side,
  input  logic [conv_pkg::ADDR_W-1:0] chan_base,
  output logic                        input_en,
  output logic [conv_pkg::ADDR_W-1:0] input_addr,
  input  conv_pkg::pixel_t            input_rdata,
  output logic                        fetch_done,
  output conv_pkg::window_t           window
);
  import conv_pkg::*;

  logic active;
  logic [1:0] tap_r;
  logic [1:0] tap_c;
  logic [1:0] cur_r;
  logic [1:0] cur_c;
  logic [3:0] cur_tap;
  logic issue;
  logic pad;
  logic [ROW_W:0] nrow;
  logic [ROW_W:0] ncol;
  logic pend_valid;
  logic pend_pad;
  logic [3:0] pend_tap;

  // tap 0 goes out in the fetch_go cycle itself
  assign issue   = fetch_go || active;
  assign cur_r   = fetch_go ? 2'd0 : tap_r;
  assign cur_c   = fetch_go ? 2'd0 : tap_c;
  assign cur_tap = {2'b00, cur_r} * 4'd3 + {2'b00, cur_c};

  // neighbour outside the image
  assign pad = (cur_r == 2'd0 && row == '0) ||
               (cur_r == 2'd2 && row == side - 1'b1) ||
               (cur_c == 2'd0 && col == '0) ||
               (cur_c == 2'd2 && col == side - 1'b1);

  // wraps below zero only for padded taps, which never read
  assign nrow = {1'b0, row} + cur_r - 1'b1;
  assign ncol = {1'b0, col} + cur_c - 1'b1;

  assign input_en   = issue && !pad;
  assign input_addr = chan_base + ADDR_W'(nrow) * ADDR_W'(side) + ADDR_W'(ncol);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      active     <= 1'b0;
      tap_r      <= '0;
      tap_c      <= '0;
      pend_valid <= 1'b0;
      pend_pad   <= 1'b0;
      pend_tap   <= '0;
    end else begin
      pend_valid <= issue;
      pend_pad   <= pad;
      pend_tap   <= cur_tap;
      if (issue) begin
        active <= cur_tap != TAPS - 1;
        tap_c  <= (cur_c == 2'd2) ? 2'd0 : cur_c + 1'b1;
        tap_r  <= (cur_c == 2'd2) ? cur_r + 1'b1 : cur_r;
      end
    end
  end

  // read data lands one cycle after the address
  always_ff @(posedge clk) begin
    if (pend_valid) window[pend_tap] <= pend_pad ? '0 : input_rdata;
  end

  assign fetch_done = pend_valid && (pend_tap == TAPS - 1);

endmodule
